/* filelist.f */
hdl/ring_pkg.sv
hdl/periodic_trigger.sv
hdl/packet_tx.sv
hdl/packet_rx.sv
hdl/sync_timer_master.sv
hdl/ring_master.sv
tb/ring_master_tb.sv

/* hdl/packet_rx.sv */
`timescale 1ns/1ps

module packet_rx (
    input  logic                   clk,
    input  logic                   reset,

    input  ring_pkg::ring_byte_t   down_rx,
    input  logic                   down_rx_valid,

    output ring_pkg::ring_header_t rx_header,
    output logic                   rx_header_valid,

    output logic [7:0]             payload_data,
    output logic [15:0]            payload_pos,
    output logic                   payload_last,
    output logic                   payload_valid,

    output logic                   rx_end,
    output logic                   rx_error
);

    typedef enum logic [1:0] {
        st_idle,
        st_header,
        st_payload
    } state_t;

    state_t      state;
    logic [1:0]  hdr_cnt;
    logic [15:0] pay_cnt;
    logic        err;
    logic        pay_end;

    // packet ends on last or when the length count is used up
    assign pay_end = down_rx.last || (pay_cnt == rx_header.length);

    // --------------------
    // framing
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= st_idle;
            hdr_cnt         <= '0;
            pay_cnt         <= '0;
            err             <= 1'b0;
            rx_header_valid <= 1'b0;
            payload_valid   <= 1'b0;
            rx_end          <= 1'b0;
            rx_error        <= 1'b0;
        end else begin
            rx_header_valid <= 1'b0;
            payload_valid   <= 1'b0;
            rx_end          <= 1'b0;
            rx_error        <= 1'b0;
            if (down_rx_valid) begin
                case (state)
                    st_idle: begin
                        // stray bytes outside a packet are dropped
                        if (down_rx.first) begin
                            hdr_cnt <= 2'd1;
                            err     <= 1'b0;
                            if (down_rx.last) begin
                                rx_end   <= 1'b1;
                                rx_error <= 1'b1;
                            end else begin
                                state <= st_header;
                            end
                        end
                    end
                    st_header: begin
                        hdr_cnt <= hdr_cnt + 2'd1;
                        err     <= err | down_rx.first;
                        if (down_rx.last) begin
                            // header cut short
                            rx_end   <= 1'b1;
                            rx_error <= 1'b1;
                            state    <= st_idle;
                        end else if (hdr_cnt == 2'(ring_pkg::header_len - 1)) begin
                            rx_header_valid <= 1'b1;
                            pay_cnt         <= '0;
                            state           <= st_payload;
                        end
                    end
                    default: begin
                        payload_valid <= 1'b1;
                        pay_cnt       <= pay_cnt + 16'd1;
                        err           <= err | down_rx.first;
                        if (pay_end) begin
                            rx_end   <= 1'b1;
                            rx_error <= err | down_rx.first | !down_rx.last |
                                        (pay_cnt != rx_header.length);
                            state    <= st_idle;
                        end
                    end
                endcase
            end
        end
    end

    // --------------------
    // header and payload data
    // --------------------

    always_ff @(posedge clk) begin
        if (down_rx_valid) begin
            if (state == st_idle && down_rx.first) begin
                rx_header.pkt_type <= down_rx.data;
            end
            if (state == st_header) begin
                case (hdr_cnt)
                    2'd1:    rx_header.node          <= down_rx.data;
                    2'd2:    rx_header.length[7:0]  <= down_rx.data;
                    default: rx_header.length[15:8] <= down_rx.data;
                endcase
            end
            if (state == st_payload) begin
                payload_data <= down_rx.data;
                payload_pos  <= pay_cnt;
                payload_last <= pay_end;
            end
        end
    end

endmodule

/* hdl/packet_tx.sv */
`timescale 1ns/1ps

module packet_tx (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   tx_start,
    input  ring_pkg::ring_header_t tx_header,

    input  logic [7:0]             payload_data,
    input  logic                   payload_last,
    input  logic                   payload_valid,
    output logic                   payload_ready,

    output ring_pkg::ring_byte_t   down_tx,
    output logic                   down_tx_valid,
    input  logic                   down_tx_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_header,
        st_payload
    } state_t;

    state_t                 state;
    ring_pkg::ring_header_t hdr;
    logic [1:0]             hdr_idx;
    logic [7:0]             hdr_byte;

    // wire order: type, node, length low, length high
    always_comb begin
        case (hdr_idx)
            2'd0:    hdr_byte = hdr.pkt_type;
            2'd1:    hdr_byte = hdr.node;
            2'd2:    hdr_byte = hdr.length[7:0];
            default: hdr_byte = hdr.length[15:8];
        endcase
    end

    // --------------------
    // output mux
    // --------------------

    always_comb begin
        down_tx       = '0;
        down_tx_valid = 1'b0;
        payload_ready = 1'b0;
        case (state)
            st_header: begin
                down_tx.first = (hdr_idx == 2'd0);
                down_tx.data  = hdr_byte;
                down_tx_valid = 1'b1;
            end
            st_payload: begin
                down_tx.last  = payload_last;
                down_tx.data  = payload_data;
                down_tx_valid = payload_valid;
                payload_ready = down_tx_ready;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_idle;
            hdr_idx <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (tx_start) begin
                        state   <= st_header;
                        hdr_idx <= '0;
                    end
                end
                st_header: begin
                    if (down_tx_ready) begin
                        hdr_idx <= hdr_idx + 2'd1;
                        if (hdr_idx == 2'(ring_pkg::header_len - 1)) begin
                            state <= st_payload;
                        end
                    end
                end
                default: begin
                    if (payload_valid && down_tx_ready && payload_last) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // header held for the whole frame
    always_ff @(posedge clk) begin
        if (state == st_idle && tx_start) begin
            hdr <= tx_header;
        end
    end

endmodule

/* hdl/periodic_trigger.sv */
`timescale 1ns/1ps

module periodic_trigger (
    input  logic                               clk,
    input  logic                               reset,
    output logic [ring_pkg::timer_width-1:0]   current_time,
    output logic                               trigger
);

    logic [ring_pkg::timer_width-1:0] next_boundary;

    // hits exactly since sync_period is a multiple of time_step
    assign trigger = (current_time == next_boundary);

    always_ff @(posedge clk) begin
        if (reset) begin
            current_time  <= '0;
            next_boundary <= ring_pkg::sync_period;
        end else begin
            current_time <= current_time + ring_pkg::time_step;
            if (trigger) begin
                next_boundary <= next_boundary + ring_pkg::sync_period;
            end
        end
    end

endmodule

/* hdl/ring_master.sv */
`timescale 1ns/1ps

module ring_master (
    input  logic                             clk,
    input  logic                             reset,
    output logic [ring_pkg::timer_width-1:0] current_time,

    output ring_pkg::ring_byte_t             down_tx,
    output logic                             down_tx_valid,
    input  logic                             down_tx_ready,

    input  ring_pkg::ring_byte_t             down_rx,
    input  logic                             down_rx_valid,

    output logic [ring_pkg::timer_width-1:0] ring_delay,
    output logic                             ring_delay_valid,
    output logic [15:0]                      error_count
);

    logic                   trigger;
    logic                   tx_start;
    ring_pkg::ring_header_t tx_header;
    logic [7:0]             tx_payload_data;
    logic                   tx_payload_last;
    logic                   tx_payload_valid;
    logic                   tx_payload_ready;

    ring_pkg::ring_header_t rx_header;
    logic                   rx_header_valid;
    logic [7:0]             rx_payload_data;
    logic [15:0]            rx_payload_pos;
    logic                   rx_payload_valid;
    logic                   rx_end;
    logic                   rx_error;

    periodic_trigger u_periodic_trigger (
        .clk          (clk),
        .reset        (reset),
        .current_time (current_time),
        .trigger      (trigger)
    );

    sync_timer_master u_sync_timer_master (
        .clk              (clk),
        .reset            (reset),
        .current_time     (current_time),
        .trigger          (trigger),
        .tx_start         (tx_start),
        .tx_header        (tx_header),
        .payload_data     (tx_payload_data),
        .payload_last     (tx_payload_last),
        .payload_valid    (tx_payload_valid),
        .payload_ready    (tx_payload_ready),
        .rx_header        (rx_header),
        .rx_header_valid  (rx_header_valid),
        .rx_payload_data  (rx_payload_data),
        .rx_payload_pos   (rx_payload_pos),
        .rx_payload_valid (rx_payload_valid),
        .rx_end           (rx_end),
        .rx_error         (rx_error),
        .ring_delay       (ring_delay),
        .ring_delay_valid (ring_delay_valid),
        .error_count      (error_count)
    );

    // outgoing side of the ring
    packet_tx u_packet_tx (
        .clk           (clk),
        .reset         (reset),
        .tx_start      (tx_start),
        .tx_header     (tx_header),
        .payload_data  (tx_payload_data),
        .payload_last  (tx_payload_last),
        .payload_valid (tx_payload_valid),
        .payload_ready (tx_payload_ready),
        .down_tx       (down_tx),
        .down_tx_valid (down_tx_valid),
        .down_tx_ready (down_tx_ready)
    );

    // returning side, end of payload is carried by rx_end
    packet_rx u_packet_rx (
        .clk             (clk),
        .reset           (reset),
        .down_rx         (down_rx),
        .down_rx_valid   (down_rx_valid),
        .rx_header       (rx_header),
        .rx_header_valid (rx_header_valid),
        .payload_data    (rx_payload_data),
        .payload_pos     (rx_payload_pos),
        .payload_last    (),
        .payload_valid   (rx_payload_valid),
        .rx_end          (rx_end),
        .rx_error        (rx_error)
    );

endmodule

/* hdl/ring_pkg.sv */
package ring_pkg;

    // --------------------
    // timing
    // --------------------

    localparam int timer_width = 64;

    // ns per clock and ns between sync packets
    localparam logic [timer_width-1:0] time_step   = 8;
    localparam logic [timer_width-1:0] sync_period = 20000;

    // periods without a return before giving up
    localparam int sync_timeout = 4;

    // --------------------
    // packet format
    // --------------------

    localparam logic [7:0] type_timesync = 8'h10;
    localparam logic [7:0] master_node   = 8'h00;

    localparam int header_len       = 4;
    localparam int sync_payload_len = 9;

    // length is payload bytes minus one
    typedef struct packed {
        logic [7:0]  pkt_type;
        logic [7:0]  node;
        logic [15:0] length;
    } ring_header_t;

    typedef struct packed {
        logic       first;
        logic       last;
        logic [7:0] data;
    } ring_byte_t;

endpackage

/* hdl/sync_timer_master.sv */
`timescale 1ns/1ps

module sync_timer_master (
    input  logic                             clk,
    input  logic                             reset,

    input  logic [ring_pkg::timer_width-1:0] current_time,
    input  logic                             trigger,

    output logic                             tx_start,
    output ring_pkg::ring_header_t           tx_header,
    output logic [7:0]                       payload_data,
    output logic                             payload_last,
    output logic                             payload_valid,
    input  logic                             payload_ready,

    input  ring_pkg::ring_header_t           rx_header,
    input  logic                             rx_header_valid,
    input  logic [7:0]                       rx_payload_data,
    input  logic [15:0]                      rx_payload_pos,
    input  logic                             rx_payload_valid,
    input  logic                             rx_end,
    input  logic                             rx_error,

    output logic [ring_pkg::timer_width-1:0] ring_delay,
    output logic                             ring_delay_valid,
    output logic [15:0]                      error_count
);

    // flag byte first, then time bytes lsb first
    logic [ring_pkg::sync_payload_len-1:0][7:0] tx_payload;
    logic [ring_pkg::timer_width-1:0]           stamp;

    logic       override;
    logic       outstanding;
    logic [2:0] timeout_cnt;
    logic       tx_active;
    logic [3:0] tx_idx;
    logic       hdr_ok;
    logic       payload_bad;
    logic       byte_bad;
    logic       send;
    logic       timeout;
    logic       good;

    assign stamp = tx_payload[ring_pkg::sync_payload_len-1:1];

    // the last payload byte arrives together with rx_end
    assign byte_bad = rx_payload_valid &&
                      (rx_payload_pos >= 16'(ring_pkg::sync_payload_len) ||
                       rx_payload_data != tx_payload[rx_payload_pos[3:0]]);

    assign send     = trigger && !outstanding && !tx_active;
    assign timeout  = trigger && outstanding &&
                      (timeout_cnt == 3'(ring_pkg::sync_timeout - 1));
    assign good     = outstanding && !rx_error && hdr_ok && !payload_bad && !byte_bad;
    assign tx_start = send;

    assign tx_header.pkt_type = ring_pkg::type_timesync;
    assign tx_header.node     = ring_pkg::master_node;
    assign tx_header.length   = 16'(ring_pkg::sync_payload_len - 1);

    assign payload_valid = tx_active;
    assign payload_data  = tx_payload[tx_idx];
    assign payload_last  = (tx_idx == 4'(ring_pkg::sync_payload_len - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            override         <= 1'b1;
            outstanding      <= 1'b0;
            timeout_cnt      <= '0;
            tx_active        <= 1'b0;
            tx_idx           <= '0;
            hdr_ok           <= 1'b0;
            payload_bad      <= 1'b0;
            ring_delay_valid <= 1'b0;
            error_count      <= '0;
        end else begin
            ring_delay_valid <= rx_end && good;
            if ((rx_end && !good) || timeout) begin
                error_count <= error_count + 16'd1;
            end

            // --------------------
            // send side
            // --------------------
            if (send) begin
                override    <= 1'b0;
                outstanding <= 1'b1;
                timeout_cnt <= '0;
                tx_active   <= 1'b1;
                tx_idx      <= '0;
            end else begin
                if (rx_end || timeout) begin
                    outstanding <= 1'b0;
                end
                if (trigger && outstanding) begin
                    timeout_cnt <= timeout_cnt + 3'd1;
                end
            end
            if (payload_valid && payload_ready) begin
                if (payload_last) begin
                    tx_active <= 1'b0;
                end else begin
                    tx_idx <= tx_idx + 4'd1;
                end
            end

            // --------------------
            // return check
            // --------------------
            if (rx_header_valid) begin
                hdr_ok <= (rx_header.pkt_type == ring_pkg::type_timesync) &&
                          (rx_header.length == 16'(ring_pkg::sync_payload_len - 1));
                payload_bad <= 1'b0;
            end else begin
                if (rx_end) begin
                    hdr_ok <= 1'b0;
                end
                if (byte_bad) begin
                    payload_bad <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            tx_payload <= {current_time, 7'b0, override};
        end
        if (rx_end) begin
            ring_delay <= current_time - stamp;
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the ring master testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -j 0 --timescale 1ns/1ps \
    --top-module ring_master_tb -f filelist.f -o ring_master_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/ring_master_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test passed" "$log"; then
    exit 0
fi
exit 1

/* tb/ring_master_tb.sv */
`timescale 1ns/1ps

module ring_master_tb;

    // one replayed byte and the cycle it goes back onto down_rx
    typedef struct packed {
        int                   due;
        ring_pkg::ring_byte_t b;
    } loop_entry_t;

    logic                             clk = 1'b0;
    logic                             reset = 1'b1;
    logic [ring_pkg::timer_width-1:0] current_time;
    ring_pkg::ring_byte_t             down_tx;
    logic                             down_tx_valid;
    logic                             down_tx_ready = 1'b0;
    ring_pkg::ring_byte_t             down_rx = '0;
    logic                             down_rx_valid = 1'b0;
    logic [ring_pkg::timer_width-1:0] ring_delay;
    logic                             ring_delay_valid;
    logic [15:0]                      error_count;

    int                               seed = 32'hb0e2;
    int                               cyc = 0;
    int                               fail_count = 0;
    loop_entry_t                      loop_q[$];

    // tx side bookkeeping
    logic [3:0]                       tx_idx = 4'd0;
    int                               tx_pkt = 0;
    int                               sent_count = 0;
    logic [12:0][7:0]                 exp_pkt;
    logic                             hold_pending = 1'b0;
    ring_pkg::ring_byte_t             held_byte;

    // 0 clean, 1 flip a middle payload byte, 2 drop last, 3 flip the last byte
    int                               corrupt_pkt = 0;
    int                               corrupt_mode = 0;

    int                               delay_count = 0;
    logic [ring_pkg::timer_width-1:0] last_time = '0;

    ring_master uut (
        .clk              (clk),
        .reset            (reset),
        .current_time     (current_time),
        .down_tx          (down_tx),
        .down_tx_valid    (down_tx_valid),
        .down_tx_ready    (down_tx_ready),
        .down_rx          (down_rx),
        .down_rx_valid    (down_rx_valid),
        .ring_delay       (ring_delay),
        .ring_delay_valid (ring_delay_valid),
        .error_count      (error_count)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            fail_count = fail_count + 1;
            $display("ERR %s got %h expected %h", name, got, want);
            $display("test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("test failed");
        $fatal(1, "timeout");
    endtask

    // 4 header bytes, flag byte, then time lsb first from byte 5
    function automatic logic [12:0][7:0] expected_packet(input logic ovr,
                                                         input logic [63:0] t);
        logic [12:0][7:0] p;
        p[0]        = ring_pkg::type_timesync;
        p[1]        = ring_pkg::master_node;
        {p[3], p[2]} = 16'(ring_pkg::sync_payload_len - 1);
        p[4]        = {7'b0, ovr};
        p[12:5]     = t;
        return p;
    endfunction

    // --------------------
    // ready and loopback
    // --------------------

    always @(negedge clk) begin
        if (reset) begin
            down_tx_ready <= 1'b0;
        end else begin
            down_tx_ready <= (($random(seed) & 32'h3) != 32'h0);
        end
        if (loop_q.size() > 0 && loop_q[0].due == cyc) begin
            down_rx       <= loop_q[0].b;
            down_rx_valid <= 1'b1;
            void'(loop_q.pop_front());
        end else begin
            down_rx       <= '0;
            down_rx_valid <= 1'b0;
        end
    end

    // compare every accepted byte, then queue it for the return trip
    always @(posedge clk) begin : tx_monitor
        loop_entry_t ent;
        if (!reset) begin
            if (hold_pending) begin
                check_equal("down_tx_valid", 64'(down_tx_valid), 64'h1);
                check_equal("down_tx", 64'(down_tx), 64'(held_byte));
            end
            hold_pending = down_tx_valid && !down_tx_ready;
            held_byte    = down_tx;
            if (down_tx_valid && down_tx_ready) begin
                if (tx_idx == 4'd0) begin
                    tx_pkt  = tx_pkt + 1;
                    exp_pkt = expected_packet(tx_pkt == 1,
                                              64'(tx_pkt) * ring_pkg::sync_period);
                end
                check_equal("down_tx.data", 64'(down_tx.data), 64'(exp_pkt[tx_idx]));
                check_equal("down_tx.first", 64'(down_tx.first), 64'(tx_idx == 4'd0));
                check_equal("down_tx.last", 64'(down_tx.last), 64'(tx_idx == 4'd12));
                ent.due = cyc + 10;
                ent.b   = down_tx;
                if (tx_pkt == corrupt_pkt &&
                    ((corrupt_mode == 1 && tx_idx == 4'd6) ||
                     (corrupt_mode == 3 && tx_idx == 4'd12))) begin
                    ent.b.data = ent.b.data ^ 8'h5a;
                end
                if (tx_pkt == corrupt_pkt && corrupt_mode == 2 && tx_idx == 4'd12) begin
                    ent.b.last = 1'b0;
                end
                loop_q.push_back(ent);
                if (tx_idx == 4'd12) begin
                    tx_idx     = 4'd0;
                    sent_count = sent_count + 1;
                end else begin
                    tx_idx = tx_idx + 4'd1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && ring_delay_valid) begin
            check_equal("ring_delay", ring_delay,
                        last_time - 64'(tx_pkt) * ring_pkg::sync_period);
            delay_count = delay_count + 1;
        end
        last_time = current_time;
    end

    // --------------------
    // sequence
    // --------------------

    task automatic run_packet(input int k, input int mode);
        logic [15:0] e0;
        int          d0;
        int          n;
        corrupt_pkt  = k;
        corrupt_mode = mode;
        e0 = error_count;
        d0 = delay_count;
        n  = 0;
        while (sent_count < k) begin
            @(negedge clk);
            n = n + 1;
            if (n > 3000) begin
                report_timeout($sformatf("packet %0d to be sent", k));
            end
        end
        n = 0;
        while (delay_count == d0 && error_count == e0) begin
            @(negedge clk);
            n = n + 1;
            if (n > 200) begin
                report_timeout($sformatf("a delay or error for packet %0d", k));
            end
        end
        @(negedge clk);
        if (mode == 0) begin
            check_equal("delay pulses", 64'(delay_count), 64'(d0 + 1));
            check_equal("error_count", 64'(error_count), 64'(e0));
        end else begin
            check_equal("delay pulses", 64'(delay_count), 64'(d0));
            check_equal("error_count", 64'(error_count), 64'(e0 + 16'd1));
        end
    endtask

    initial begin
        repeat (5) @(negedge clk);
        check_equal("down_tx_valid", 64'(down_tx_valid), 64'h0);
        check_equal("ring_delay_valid", 64'(ring_delay_valid), 64'h0);
        check_equal("error_count", 64'(error_count), 64'h0);
        check_equal("current_time", current_time, 64'h0);
        reset <= 1'b0;
        for (int n = 1; n <= 10; n++) begin
            @(negedge clk);
            check_equal("current_time", current_time, 64'(n) * ring_pkg::time_step);
        end

        run_packet(1, 0);
        run_packet(2, 0);
        run_packet(3, 1);
        run_packet(4, 2);
        run_packet(5, 3);
        run_packet(6, 0);

        if (fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
